// ==== save_config.svh ====
`ifndef SAVE_CONFIG_SVH
`define SAVE_CONFIG_SVH

//////////////////////////////////////////////////////////////////////
// eeprom geometry
//////////////////////////////////////////////////////////////////////

`define SAVE_ADDR_W    13      // 8 KB image
`define SAVE_DATA_W    8

// backup source addressing
`define SAVE_OFFSET_W  9       // byte offset within a 512 byte sector
`define SAVE_LBA_W     4       // low sector bits, sixteen sectors

// loader queue depth, also credits held by the source after reset
`define BK_CREDITS     4

//////////////////////////////////////////////////////////////////////
// rtc stamp layout
//////////////////////////////////////////////////////////////////////

`define RTC_HDR_LEN    11      // validation header bytes
`define RTC_STAMP_LEN  18      // header + six time fields + checksum

// year byte, the remaining fields follow, checksum lands on 1fff
`define RTC_TIME_BASE  13'h1FF9

`endif

// ==== save_pkg.sv ====
`default_nettype none

`include "save_config.svh"

package save_pkg;

  // data and address words of the eeprom image
  typedef logic [`SAVE_DATA_W-1:0] byte_t;
  typedef logic [`SAVE_ADDR_W-1:0] eeprom_addr_t;

  // stamp writer sequence
  typedef enum logic [1:0] {
    IDLE,      // waiting for a start pulse
    HEADER,    // validation header bytes
    TIME,      // converted year .. second
    CHECKSUM   // 8-bit sum of the time fields
  } rtc_state_e;

  // writer holding the ram write port this cycle
  typedef enum logic [1:0] {
    NONE,
    RTC,
    BACKUP
  } wr_owner_e;

endpackage

`default_nettype wire

// ==== rtc_stamp_writer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "save_config.svh"

module rtc_stamp_writer (
  input  wire                    clk_sys_32,
  input  wire                    reset,
  input  wire                    rtc_start,
  input  wire [63:0]             rtc_timestamp,  // bcd, lanes as delivered by the rtc
  input  wire                    rtc_grant,
  output logic                   rtc_req,
  output save_pkg::eeprom_addr_t rtc_addr,
  output save_pkg::byte_t        rtc_data,
  output logic                   rtc_busy
);

  localparam int IDX_W = $clog2(`RTC_STAMP_LEN);
  localparam int N_FIELDS = `RTC_STAMP_LEN - `RTC_HDR_LEN - 1;

  // validation header, written before the time fields
  localparam save_pkg::eeprom_addr_t HDR_ADDR [0:`RTC_HDR_LEN-1] = '{
    13'h0000, 13'h0001, 13'h0002, 13'h0003,
    13'h1FF2, 13'h1FF3, 13'h1FF4, 13'h1FF5,
    13'h1FF6, 13'h1FF7, 13'h1FF8
  };
  localparam save_pkg::byte_t HDR_DATA [0:`RTC_HDR_LEN-1] = '{
    8'h47, 8'h42, 8'h4D, 8'h4E,  // "GBMN"
    8'h01, 8'h03, 8'h01, 8'h1F,
    8'h00, 8'h00, 8'h00
  };

  save_pkg::rtc_state_e state;
  logic [IDX_W-1:0]     idx;        // position in the 18 write sequence
  logic [2:0]           field_sel;  // time field being written
  save_pkg::byte_t      bcd_q [0:N_FIELDS-1];
  save_pkg::byte_t      csum;

  function automatic save_pkg::byte_t bcd2bin(input save_pkg::byte_t bcd);
    bcd2bin = save_pkg::byte_t'(bcd[7:4]) * 8'd10 + save_pkg::byte_t'(bcd[3:0]);
  endfunction

  //////////////////////////////////////////////////////////////////////
  // sequencer
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_sys_32) begin
    if (reset) begin
      state <= save_pkg::IDLE;
      idx   <= '0;
    end else begin
      case (state)
        save_pkg::IDLE: begin
          if (rtc_start) begin
            state <= save_pkg::HEADER;
            idx   <= '0;
          end
        end
        save_pkg::HEADER: begin
          if (rtc_grant) begin
            idx <= idx + 1'b1;
            if (idx == IDX_W'(`RTC_HDR_LEN - 1)) state <= save_pkg::TIME;
          end
        end
        save_pkg::TIME: begin
          if (rtc_grant) begin
            idx <= idx + 1'b1;
            if (idx == IDX_W'(`RTC_STAMP_LEN - 2)) state <= save_pkg::CHECKSUM;
          end
        end
        save_pkg::CHECKSUM: begin
          if (rtc_grant) state <= save_pkg::IDLE;  // last byte out
        end
        default: state <= save_pkg::IDLE;
      endcase
    end
  end

  // timestamp snapshot and running sum
  always_ff @(posedge clk_sys_32) begin
    if (state == save_pkg::IDLE && rtc_start) begin
      bcd_q[0] <= rtc_timestamp[55:48];  // year
      bcd_q[1] <= rtc_timestamp[47:40];  // month
      bcd_q[2] <= rtc_timestamp[39:32];  // day
      bcd_q[3] <= rtc_timestamp[23:16];  // hour
      bcd_q[4] <= rtc_timestamp[15:8];   // minute
      bcd_q[5] <= rtc_timestamp[7:0];    // second
      csum     <= '0;
    end else if (state == save_pkg::TIME && rtc_grant) begin
      csum <= csum + rtc_data;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // request side
  //////////////////////////////////////////////////////////////////////

  assign rtc_busy = (state != save_pkg::IDLE);
  assign rtc_req  = (state != save_pkg::IDLE);

  always_comb begin
    field_sel = 3'(idx - IDX_W'(`RTC_HDR_LEN));
    case (state)
      save_pkg::HEADER: begin
        rtc_addr = HDR_ADDR[idx[3:0]];
        rtc_data = HDR_DATA[idx[3:0]];
      end
      save_pkg::TIME: begin
        rtc_addr = `RTC_TIME_BASE + save_pkg::eeprom_addr_t'(field_sel);
        rtc_data = bcd2bin(bcd_q[field_sel]);
      end
      save_pkg::CHECKSUM: begin
        rtc_addr = `RTC_TIME_BASE + save_pkg::eeprom_addr_t'(N_FIELDS);
        rtc_data = csum;
      end
      default: begin
        rtc_addr = '0;
        rtc_data = '0;
      end
    endcase
  end

  // top priority at the arbiter keeps the stamp to one write per cycle
  a_stamp_len: assert property (@(posedge clk_sys_32) disable iff (reset)
    $rose(rtc_busy) |-> rtc_busy [*`RTC_STAMP_LEN] ##1 !rtc_busy);

endmodule

`default_nettype wire

// ==== backup_loader.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "save_config.svh"

module backup_loader (
  input  wire                     clk_sys_32,
  input  wire                     reset,
  input  wire                     bk_valid,
  input  wire [`SAVE_LBA_W-1:0]   bk_lba,
  input  wire [`SAVE_OFFSET_W-1:0] bk_offset,
  input  wire save_pkg::byte_t    bk_data,
  input  wire                     bk_grant,
  output logic                    bk_req,
  output save_pkg::eeprom_addr_t  bk_addr,
  output save_pkg::byte_t         bk_wdata,
  output logic                    bk_credit
);

  localparam int PTR_W = $clog2(`BK_CREDITS);

  // queue storage, one entry per outstanding credit
  save_pkg::eeprom_addr_t q_addr [0:`BK_CREDITS-1];
  save_pkg::byte_t        q_data [0:`BK_CREDITS-1];

  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W:0]   count;
  logic             full;
  logic             push;
  logic             pop;

  assign full = (count == (PTR_W+1)'(`BK_CREDITS));
  assign push = bk_valid && !full;
  assign pop  = bk_req && bk_grant;  // head written this edge

  //////////////////////////////////////////////////////////////////////
  // write side
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_sys_32) begin
    if (push) begin
      q_addr[wr_ptr] <= {bk_lba, bk_offset};  // sector low bits over offset
      q_data[wr_ptr] <= bk_data;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // pointers and occupancy
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_sys_32) begin
    if (reset) begin
      wr_ptr    <= '0;
      rd_ptr    <= '0;
      count     <= '0;
      bk_credit <= 1'b0;
    end else begin
      if (push) begin
        if (wr_ptr == PTR_W'(`BK_CREDITS - 1)) wr_ptr <= '0;
        else wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        if (rd_ptr == PTR_W'(`BK_CREDITS - 1)) rd_ptr <= '0;
        else rd_ptr <= rd_ptr + 1'b1;
      end

      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // idle or push and pop together
      endcase

      bk_credit <= pop;  // one credit back per byte landed
    end
  end

  // head of queue goes straight to the arbiter
  assign bk_req   = (count != '0);
  assign bk_addr  = q_addr[rd_ptr];
  assign bk_wdata = q_data[rd_ptr];

  // a byte with the queue full means the source sent without a credit
  a_credit_rule: assert property (@(posedge clk_sys_32) disable iff (reset)
    bk_valid |-> !full);

endmodule

`default_nettype wire

// ==== eeprom_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module eeprom_arbiter (
  input  wire                         clk_sys_32,
  input  wire                         reset,
  input  wire                         rtc_req,
  input  wire save_pkg::eeprom_addr_t rtc_addr,
  input  wire save_pkg::byte_t        rtc_data,
  input  wire                         bk_req,
  input  wire save_pkg::eeprom_addr_t bk_addr,
  input  wire save_pkg::byte_t        bk_wdata,
  output logic                        rtc_grant,
  output logic                        bk_grant,
  output logic                        mem_we,
  output save_pkg::eeprom_addr_t      mem_addr,
  output save_pkg::byte_t             mem_wdata,
  output save_pkg::wr_owner_e         owner
);

  save_pkg::wr_owner_e owner_q;

  // rtc first, backup only when the rtc side is quiet
  always_comb begin
    if (rtc_req) owner = save_pkg::RTC;
    else if (bk_req) owner = save_pkg::BACKUP;
    else owner = save_pkg::NONE;
  end

  always_comb begin
    rtc_grant = 1'b0;
    bk_grant  = 1'b0;
    mem_we    = 1'b0;
    mem_addr  = bk_addr;
    mem_wdata = bk_wdata;
    case (owner)
      save_pkg::RTC: begin
        rtc_grant = 1'b1;
        mem_we    = 1'b1;
        mem_addr  = rtc_addr;
        mem_wdata = rtc_data;
      end
      save_pkg::BACKUP: begin
        bk_grant = 1'b1;
        mem_we   = 1'b1;
      end
      default: ;  // port idle
    endcase
  end

  always_ff @(posedge clk_sys_32) begin
    if (reset) owner_q <= save_pkg::NONE;
    else owner_q <= owner;
  end

  a_grant_onehot: assert property (@(posedge clk_sys_32) disable iff (reset)
    $onehot0({rtc_grant, bk_grant}));

  // last cycle's owner must have been asking
  a_grant_backed: assert property (@(posedge clk_sys_32) disable iff (reset)
    (owner_q != save_pkg::RTC || $past(rtc_req)) &&
    (owner_q != save_pkg::BACKUP || $past(bk_req && !rtc_req)));

endmodule

`default_nettype wire

// ==== eeprom_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "save_config.svh"

module eeprom_ram (
  input  wire                         clk_sys_32,
  input  wire                         mem_we,
  input  wire save_pkg::eeprom_addr_t mem_addr,
  input  wire save_pkg::byte_t        mem_wdata,
  input  wire save_pkg::eeprom_addr_t rd_addr,
  output save_pkg::byte_t             rd_data
);

  localparam int DEPTH = 1 << `SAVE_ADDR_W;

  //////////////////////////////////////////////////////////////////////
  // 8 KB image, one write port, one read port
  //////////////////////////////////////////////////////////////////////

  save_pkg::byte_t mem [0:DEPTH-1];

  always_ff @(posedge clk_sys_32) begin
    if (mem_we) begin
      mem[mem_addr] <= mem_wdata;
    end
  end

  // same address as a write in this cycle returns the old byte
  always_ff @(posedge clk_sys_32) begin
    rd_data <= mem[rd_addr];
  end

endmodule

`default_nettype wire

// ==== save_memory.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "save_config.svh"

module save_memory (
  input  wire                         clk_sys_32,
  input  wire                         reset,
  // rtc stamp
  input  wire                         rtc_start,
  input  wire [63:0]                  rtc_timestamp,
  output logic                        rtc_busy,
  // backup bytes, credit flow
  input  wire                         bk_valid,
  input  wire [`SAVE_LBA_W-1:0]       bk_lba,
  input  wire [`SAVE_OFFSET_W-1:0]    bk_offset,
  input  wire save_pkg::byte_t        bk_data,
  output logic                        bk_credit,
  // save-back read
  input  wire save_pkg::eeprom_addr_t rd_addr,
  output save_pkg::byte_t             rd_data
);

  wire                         rtc_req;
  wire                         rtc_grant;
  wire save_pkg::eeprom_addr_t rtc_addr;
  wire save_pkg::byte_t        rtc_data;

  wire                         bk_req;
  wire                         bk_grant;
  wire save_pkg::eeprom_addr_t bk_addr;
  wire save_pkg::byte_t        bk_wdata;

  wire                         mem_we;
  wire save_pkg::eeprom_addr_t mem_addr;
  wire save_pkg::byte_t        mem_wdata;

  rtc_stamp_writer u_rtc (
    .clk_sys_32    (clk_sys_32),
    .reset         (reset),
    .rtc_start     (rtc_start),
    .rtc_timestamp (rtc_timestamp),
    .rtc_grant     (rtc_grant),
    .rtc_req       (rtc_req),
    .rtc_addr      (rtc_addr),
    .rtc_data      (rtc_data),
    .rtc_busy      (rtc_busy)
  );

  backup_loader u_bk (
    .clk_sys_32 (clk_sys_32),
    .reset      (reset),
    .bk_valid   (bk_valid),
    .bk_lba     (bk_lba),
    .bk_offset  (bk_offset),
    .bk_data    (bk_data),
    .bk_grant   (bk_grant),
    .bk_req     (bk_req),
    .bk_addr    (bk_addr),
    .bk_wdata   (bk_wdata),
    .bk_credit  (bk_credit)
  );

  eeprom_arbiter u_arb (
    .clk_sys_32 (clk_sys_32),
    .reset      (reset),
    .rtc_req    (rtc_req),
    .rtc_addr   (rtc_addr),
    .rtc_data   (rtc_data),
    .bk_req     (bk_req),
    .bk_addr    (bk_addr),
    .bk_wdata   (bk_wdata),
    .rtc_grant  (rtc_grant),
    .bk_grant   (bk_grant),
    .mem_we     (mem_we),
    .mem_addr   (mem_addr),
    .mem_wdata  (mem_wdata),
    .owner      ()
  );

  eeprom_ram u_ram (
    .clk_sys_32 (clk_sys_32),
    .mem_we     (mem_we),
    .mem_addr   (mem_addr),
    .mem_wdata  (mem_wdata),
    .rd_addr    (rd_addr),
    .rd_data    (rd_data)
  );

endmodule

`default_nettype wire

// ==== tb_save_memory.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "save_config.svh"

module tb_save_memory;

  localparam int MAX_CMDS = 64;

  logic                      clk_sys_32;
  logic                      reset;
  logic                      rtc_start;
  logic [63:0]               rtc_timestamp;
  logic                      rtc_busy;
  logic                      bk_valid;
  logic [`SAVE_LBA_W-1:0]    bk_lba;
  logic [`SAVE_OFFSET_W-1:0] bk_offset;
  logic [`SAVE_DATA_W-1:0]   bk_data;
  logic                      bk_credit;
  logic [`SAVE_ADDR_W-1:0]   rd_addr;
  logic [`SAVE_DATA_W-1:0]   rd_data;

  // command table, filled from the stimulus file
  logic [7:0]  cmd_op [0:MAX_CMDS-1];
  logic [63:0] cmd_a  [0:MAX_CMDS-1];
  logic [63:0] cmd_b  [0:MAX_CMDS-1];
  logic [63:0] cmd_c  [0:MAX_CMDS-1];
  logic [63:0] cmd_d  [0:MAX_CMDS-1];
  int          n_cmds;
  int          wait_sum;

  logic [7:0]              shadow [0:(1 << `SAVE_ADDR_W)-1];  // expected image
  logic [`SAVE_ADDR_W-1:0] burst_addr [$];

  int     sent;      // backup bytes handed to the dut
  int     returned;  // bk_credit pulses seen
  int     cycle_cnt;
  int     cycle_limit;
  integer seed;

  save_memory dut0 (
    .clk_sys_32    (clk_sys_32),
    .reset         (reset),
    .rtc_start     (rtc_start),
    .rtc_timestamp (rtc_timestamp),
    .rtc_busy      (rtc_busy),
    .bk_valid      (bk_valid),
    .bk_lba        (bk_lba),
    .bk_offset     (bk_offset),
    .bk_data       (bk_data),
    .bk_credit     (bk_credit),
    .rd_addr       (rd_addr),
    .rd_data       (rd_data)
  );

  initial begin
    clk_sys_32 = 1'b0;
    forever #10 clk_sys_32 = ~clk_sys_32;
  end

  //////////////////////////////////////////////////////////////////////
  // failure reporting
  //////////////////////////////////////////////////////////////////////

  task automatic fail_run;
    $display("*** FAILED ***");
    $fatal(1, "simulation stopped at first error");
  endtask

  task automatic report_err(input string name, input logic [63:0] exp, input logic [63:0] got);
    $display("ERR t=%0t %s expected %0h got %0h", $time, name, exp, got);
    fail_run;
  endtask

  // run limit from the command list
  always @(posedge clk_sys_32) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_limit != 0 && cycle_cnt >= cycle_limit) begin
      $display("timeout after %0d cycles, the command list did not finish", cycle_limit);
      fail_run;
    end
  end

  // credit bookkeeping, sampled between edge and drive point
  always @(posedge clk_sys_32) begin
    #1;
    if (!reset && bk_credit) begin
      assert (returned < sent) else begin
        $display("bk_credit pulsed with no backup byte outstanding");
        fail_run;
      end
      returned = returned + 1;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // helpers
  //////////////////////////////////////////////////////////////////////

  task automatic next_slot;
    @(posedge clk_sys_32);
    #2;
  endtask

  function automatic logic [7:0] bcd_to_bin(input logic [7:0] bcd);
    bcd_to_bin = (bcd >> 4) * 10 + (bcd & 8'h0F);
  endfunction

  // validation header, {address, byte}
  function automatic logic [20:0] header_entry(input int i);
    case (i)
      0:       header_entry = {13'h0000, 8'h47};
      1:       header_entry = {13'h0001, 8'h42};
      2:       header_entry = {13'h0002, 8'h4D};
      3:       header_entry = {13'h0003, 8'h4E};
      4:       header_entry = {13'h1FF2, 8'h01};
      5:       header_entry = {13'h1FF3, 8'h03};
      6:       header_entry = {13'h1FF4, 8'h01};
      7:       header_entry = {13'h1FF5, 8'h1F};
      8:       header_entry = {13'h1FF6, 8'h00};
      9:       header_entry = {13'h1FF7, 8'h00};
      10:      header_entry = {13'h1FF8, 8'h00};
      default: header_entry = '0;
    endcase
  endfunction

  task automatic drain;
    while (returned != sent) next_slot;
  endtask

  task automatic read_check(input logic [`SAVE_ADDR_W-1:0] addr, input logic [7:0] exp);
    rd_addr = addr;
    next_slot;
    assert (rd_data === exp) else report_err($sformatf("rd_data[%h]", addr), exp, rd_data);
  endtask

  // one byte on the bus for this cycle, caller owns the credit check
  task automatic drive_byte(input logic [`SAVE_LBA_W-1:0] lba,
                            input logic [`SAVE_OFFSET_W-1:0] off, input logic [7:0] data);
    logic [`SAVE_ADDR_W-1:0] a;
    a = lba * (1 << `SAVE_OFFSET_W) + off;  // sector bits above the offset
    bk_valid  = 1'b1;
    bk_lba    = lba;
    bk_offset = off;
    bk_data   = data;
    sent      = sent + 1;
    shadow[a] = data;
  endtask

  task automatic send_byte(input logic [`SAVE_LBA_W-1:0] lba,
                           input logic [`SAVE_OFFSET_W-1:0] off, input logic [7:0] data);
    while (sent - returned >= `BK_CREDITS) next_slot;  // source stalls without credit
    drive_byte(lba, off, data);
    next_slot;
    bk_valid = 1'b0;
  endtask

  //////////////////////////////////////////////////////////////////////
  // stamp, with an optional random backup burst while busy
  //////////////////////////////////////////////////////////////////////

  task automatic run_stamp(input logic [63:0] ts, input int burst);
    logic [7:0]              field [0:5];
    logic [7:0]              sum;
    logic [20:0]             ent;
    logic [31:0]             r;
    logic [`SAVE_ADDR_W-1:0] a;
    int                      busy_cycles;
    int                      nsent;
    int                      i;
    drain;
    burst_addr.delete();
    field[0] = bcd_to_bin(ts[55:48]);  // year
    field[1] = bcd_to_bin(ts[47:40]);
    field[2] = bcd_to_bin(ts[39:32]);
    field[3] = bcd_to_bin(ts[23:16]);  // hour
    field[4] = bcd_to_bin(ts[15:8]);
    field[5] = bcd_to_bin(ts[7:0]);
    sum = '0;
    for (i = 0; i < 6; i++) sum = sum + field[i];
    for (i = 0; i < `RTC_HDR_LEN; i++) begin
      ent = header_entry(i);
      shadow[ent[20:8]] = ent[7:0];
    end
    for (i = 0; i < 6; i++) shadow[`RTC_TIME_BASE + i] = field[i];
    shadow[`RTC_TIME_BASE + 6] = sum;

    rtc_timestamp = ts;
    rtc_start     = 1'b1;
    next_slot;
    rtc_start   = 1'b0;
    busy_cycles = 0;
    nsent       = 0;
    while (rtc_busy) begin
      busy_cycles = busy_cycles + 1;
      assert (bk_credit == 1'b0) else report_err("bk_credit", 0, bk_credit);
      if (nsent < burst && sent - returned < `BK_CREDITS) begin
        r = $random(seed);
        drive_byte(r[3:0], r[12:4], r[20:13]);
        burst_addr.push_back(r[3:0] * (1 << `SAVE_OFFSET_W) + r[12:4]);
        nsent = nsent + 1;
      end else begin
        bk_valid = 1'b0;
      end
      next_slot;
    end
    bk_valid = 1'b0;
    assert (busy_cycles == `RTC_STAMP_LEN)
      else report_err("rtc_busy cycles", `RTC_STAMP_LEN, busy_cycles);

    drain;  // queued bytes land after the stamp
    for (i = 0; i < `RTC_HDR_LEN; i++) begin
      ent = header_entry(i);
      read_check(ent[20:8], shadow[ent[20:8]]);
    end
    for (i = 0; i < 7; i++) begin
      a = `RTC_TIME_BASE + i;
      read_check(a, shadow[a]);
    end
    foreach (burst_addr[i]) read_check(burst_addr[i], shadow[burst_addr[i]]);
  endtask

  // read held on the target while the byte is written
  task automatic same_cycle_check(input logic [`SAVE_LBA_W-1:0] lba,
                                  input logic [`SAVE_OFFSET_W-1:0] off,
                                  input logic [7:0] data, input logic [7:0] old);
    drain;
    rd_addr = lba * (1 << `SAVE_OFFSET_W) + off;
    drive_byte(lba, off, data);
    next_slot;
    bk_valid = 1'b0;
    while (!bk_credit) next_slot;
    // write edge just passed, the read at that edge saw the old byte
    assert (rd_data === old) else report_err("rd_data same cycle", old, rd_data);
    next_slot;
    assert (rd_data === data) else report_err("rd_data after write", data, rd_data);
  endtask

  //////////////////////////////////////////////////////////////////////
  // stimulus file
  //////////////////////////////////////////////////////////////////////

  task automatic load_stimulus;
    int               fd;
    int               code;
    int               need;
    logic [63:0]      tok;
    logic [63:0]      ta;
    logic [63:0]      tb;
    logic [63:0]      tc;
    logic [63:0]      td;
    logic [8*256-1:0] line_buf;
    fd = $fopen("save_stimulus.txt", "r");
    if (fd == 0) begin
      $display("could not open save_stimulus.txt");
      fail_run;
    end
    n_cmds   = 0;
    wait_sum = 0;
    code = $fscanf(fd, "%s", tok);
    while (code == 1) begin
      ta = '0;
      tb = '0;
      tc = '0;
      td = '0;
      need = 0;
      case (tok)
        "#": begin
          code = $fgets(line_buf, fd);  // comment line
          need = -1;
        end
        "B": begin
          code = $fscanf(fd, "%h %h %h", ta, tb, tc);
          need = 3;
        end
        "T": begin
          code = $fscanf(fd, "%h", ta);
          need = 1;
        end
        "R", "S": begin
          code = $fscanf(fd, "%h %h", ta, tb);
          need = 2;
        end
        "W": begin
          code = $fscanf(fd, "%d", ta);
          need = 1;
          wait_sum = wait_sum + ta;
        end
        "C": begin
          code = $fscanf(fd, "%h %h %h %h", ta, tb, tc, td);
          need = 4;
        end
        default: begin
          $display("unknown command in stimulus file after %0d commands", n_cmds);
          fail_run;
        end
      endcase
      if (need > 0) begin
        if (code < need || n_cmds == MAX_CMDS) begin
          $display("malformed or excess command line in stimulus file");
          fail_run;
        end
        cmd_op[n_cmds] = tok[7:0];
        cmd_a[n_cmds]  = ta;
        cmd_b[n_cmds]  = tb;
        cmd_c[n_cmds]  = tc;
        cmd_d[n_cmds]  = td;
        n_cmds = n_cmds + 1;
      end
      code = $fscanf(fd, "%s", tok);
    end
    $fclose(fd);
  endtask

  //////////////////////////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////////////////////////

  initial begin : run_tests
    int i;
    reset         = 1'b1;
    rtc_start     = 1'b0;
    rtc_timestamp = '0;
    bk_valid      = 1'b0;
    bk_lba        = '0;
    bk_offset     = '0;
    bk_data       = '0;
    rd_addr       = '0;
    seed          = 16;
    sent          = 0;
    returned      = 0;
    cycle_cnt     = 0;
    cycle_limit   = 0;
    load_stimulus;
    cycle_limit = 2 * wait_sum + 40 * n_cmds;

    repeat (4) @(posedge clk_sys_32);
    #2;
    reset = 1'b0;
    for (i = 0; i < 3; i++) begin  // quiet outputs before any command
      assert (rtc_busy == 1'b0) else report_err("rtc_busy", 0, rtc_busy);
      assert (bk_credit == 1'b0) else report_err("bk_credit", 0, bk_credit);
      next_slot;
    end

    for (i = 0; i < n_cmds; i++) begin
      case (cmd_op[i])
        "B": send_byte(cmd_a[i][3:0], cmd_b[i][8:0], cmd_c[i][7:0]);
        "T": run_stamp(cmd_a[i], 0);
        "S": run_stamp(cmd_a[i], cmd_b[i]);
        "W": repeat (cmd_a[i]) next_slot;
        "R": begin
          drain;
          read_check(cmd_a[i][12:0], cmd_b[i][7:0]);
        end
        "C": same_cycle_check(cmd_a[i][3:0], cmd_b[i][8:0], cmd_c[i][7:0], cmd_d[i][7:0]);
        default: ;
      endcase
    end

    next_slot;
    if (sent == returned) begin
      $display("*** PASSED ***");
      $finish;
    end else begin
      $display("backup bytes still waiting for credits at end of run");
      fail_run;
    end
  end

endmodule

`default_nettype wire

// ==== save_stimulus.txt ====
# B lba offset data | T bcd_time | S bcd_time burst_len | W cycles
# R addr expected | C lba offset data old_byte (read during its own write)
W 3
B 0 010 a5
B 3 1ff 5c
B f 1f0 e7
B f 000 19
B f 1fb 6d
R 0010 a5
R 07ff 5c
R 1ff0 e7
R 1e00 19
R 1ffb 6d
T 0024031500134759
R 0000 47
R 1ff5 1f
R 1ff9 18
R 1ffb 0f
R 1ffe 3b
R 1fff a1
W 4
S 0099123100235959 4
W 2
B f 1f9 77
R 1ff9 77
B 1 020 11
B 1 020 22
R 0220 22
B 2 040 aa
C 2 040 3c aa
R 0440 3c

// ==== sim.f ====
+incdir+.
save_pkg.sv
rtc_stamp_writer.sv
backup_loader.sv
eeprom_arbiter.sv
eeprom_ram.sv
save_memory.sv
tb_save_memory.sv
